//--- hdl/blit_pkg.sv
`default_nettype none

package blit_pkg;

    // bus widths
    localparam int coord_w      = 16;  // screen and command coordinates
    localparam int sheet_addr_w = 24;  // sheet word address
    localparam int fb_addr_w    = 20;  // framebuffer pixel address

    // framebuffer geometry, one rgb565 word per pixel
    localparam int fb_width     = 320;

    // pixel and colour formats
    localparam int index_w       = 4;   // colour index stored per sheet word
    localparam int color_w       = 16;  // rgb565
    localparam int palette_depth = 16;

    // per-axis scaling behaviour
    typedef enum logic {
        upscale,    // repeat each sheet pixel n times
        downscale   // skip n sheet pixels per output pixel
    } scale_mode_t;

    // coordinate generator FSM
    typedef enum logic {
        idle,
        generating
    } gen_state_t;

    // two-entry output buffer occupancy
    typedef enum logic [1:0] {
        empty,      // nothing held
        full,       // one item at the output
        buf_full    // output plus one spare
    } skid_state_t;

endpackage

`default_nettype wire

//--- hdl/blit_coord_gen.sv
`default_nettype none

module blit_coord_gen import blit_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  logic [coord_w-1:0]         cmd_src_x,
    input  logic [coord_w-1:0]         cmd_src_y,
    input  logic [sheet_addr_w-1:0]    cmd_sheet_base,
    input  logic [coord_w-1:0]         cmd_sheet_width,
    input  logic [coord_w-1:0]         cmd_dst_x,
    input  logic [coord_w-1:0]         cmd_dst_y,
    input  logic [coord_w-1:0]         cmd_width,
    input  logic [coord_w-1:0]         cmd_height,
    input  logic signed [coord_w-1:0]  cmd_scale_x,
    input  logic signed [coord_w-1:0]  cmd_scale_y,
    input  logic                       cmd_mirror_x,
    input  logic                       cmd_mirror_y,

    output logic                       cg_valid,
    input  logic                       cg_ready,
    output logic [coord_w-1:0]         cg_sheet_x,
    output logic [coord_w-1:0]         cg_sheet_y,
    output logic [coord_w-1:0]         cg_screen_x,
    output logic [coord_w-1:0]         cg_screen_y,
    output logic [sheet_addr_w-1:0]    sheet_base,
    output logic [coord_w-1:0]         sheet_width,
    output logic                       gen_busy
);

    gen_state_t         state;
    scale_mode_t        mode_x, mode_y;
    logic [coord_w-1:0] step_x, step_y;  // repeat count or stride
    logic [coord_w-1:0] src_x, dst_x, dst_y, width, height;
    logic               mirror_x, mirror_y;
    logic [coord_w-1:0] x, y;            // output pixel counters
    logic [coord_w-1:0] sub_x, sub_y;    // upscale repeat counters
    logic [coord_w-1:0] ss_x, ss_y;      // current sheet position

    wire cmd_take = cmd_valid && cmd_ready;
    wire cg_take  = cg_valid && cg_ready;
    wire last_x   = (x == width - 1'b1);
    wire last_y   = (y == height - 1'b1);

    // magnitude of a signed scale, 0 counts as 1
    function automatic logic [coord_w-1:0] scale_step(input logic signed [coord_w-1:0] s);
        if (s < 0) begin
            return -s;
        end
        return (s == 0) ? coord_w'(1) : s;
    endfunction

    assign cg_sheet_x  = ss_x;
    assign cg_sheet_y  = ss_y;
    assign cg_screen_x = mirror_x ? dst_x + width - 1'b1 - x : dst_x + x;
    assign cg_screen_y = mirror_y ? dst_y + height - 1'b1 - y : dst_y + y;
    assign gen_busy    = (state == generating);

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                cmd_ready <= 1'b1;
                if (cmd_take) begin
                    src_x       <= cmd_src_x;
                    dst_x       <= cmd_dst_x;
                    dst_y       <= cmd_dst_y;
                    width       <= cmd_width;
                    height      <= cmd_height;
                    mirror_x    <= cmd_mirror_x;
                    mirror_y    <= cmd_mirror_y;
                    sheet_base  <= cmd_sheet_base;
                    sheet_width <= cmd_sheet_width;
                    mode_x      <= (cmd_scale_x < 0) ? downscale : upscale;
                    mode_y      <= (cmd_scale_y < 0) ? downscale : upscale;
                    step_x      <= scale_step(cmd_scale_x);
                    step_y      <= scale_step(cmd_scale_y);
                    x     <= '0;
                    y     <= '0;
                    sub_x <= '0;
                    sub_y <= '0;
                    ss_x  <= cmd_src_x;
                    ss_y  <= cmd_src_y;
                    if (cmd_width != '0 && cmd_height != '0) begin  // empty rect is a no-op
                        state     <= generating;
                        cmd_ready <= 1'b0;
                        cg_valid  <= 1'b1;
                    end
                end
            end
            generating: begin
                if (cg_take) begin
                    if (last_x) begin
                        x     <= '0;
                        sub_x <= '0;
                        ss_x  <= src_x;  // back to row start
                        if (last_y) begin
                            state     <= idle;
                            cg_valid  <= 1'b0;
                            cmd_ready <= 1'b1;
                        end else begin
                            y <= y + 1'b1;
                            if (mode_y == downscale) begin
                                ss_y <= ss_y + step_y;
                            end else if (sub_y == step_y - 1'b1) begin
                                sub_y <= '0;
                                ss_y  <= ss_y + 1'b1;
                            end else begin
                                sub_y <= sub_y + 1'b1;
                            end
                        end
                    end else begin
                        x <= x + 1'b1;
                        if (mode_x == downscale) begin
                            ss_x <= ss_x + step_x;
                        end else if (sub_x == step_x - 1'b1) begin
                            sub_x <= '0;
                            ss_x  <= ss_x + 1'b1;
                        end else begin
                            sub_x <= sub_x + 1'b1;
                        end
                    end
                end
            end
            default: state <= idle;
        endcase

        if (rst) begin
            state     <= idle;
            cmd_ready <= 1'b0;
            cg_valid  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/blit_addr_calc.sv
`default_nettype none

module blit_addr_calc import blit_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    cg_valid,
    output logic                    cg_ready,
    input  logic [coord_w-1:0]      cg_sheet_x,
    input  logic [coord_w-1:0]      cg_sheet_y,
    input  logic [coord_w-1:0]      cg_screen_x,
    input  logic [coord_w-1:0]      cg_screen_y,
    input  logic [sheet_addr_w-1:0] sheet_base,
    input  logic [coord_w-1:0]      sheet_width,

    output logic                    ad_valid,
    input  logic                    ad_ready,
    output logic [sheet_addr_w-1:0] ad_sheet_addr,
    output logic [fb_addr_w-1:0]    ad_fb_addr
);

    skid_state_t              state;
    logic [sheet_addr_w-1:0]  buf_sheet_addr;
    logic [fb_addr_w-1:0]     buf_fb_addr;
    logic [sheet_addr_w-1:0]  sheet_addr;
    logic [fb_addr_w-1:0]     fb_addr;

    wire in_take  = cg_valid && cg_ready;
    wire out_take = ad_valid && ad_ready;

    // one sheet word per pixel with the row stride from the command
    assign sheet_addr = sheet_base
                      + sheet_addr_w'(cg_sheet_y) * sheet_addr_w'(sheet_width)
                      + sheet_addr_w'(cg_sheet_x);
    assign fb_addr    = fb_addr_w'(cg_screen_y * fb_width) + fb_addr_w'(cg_screen_x);

    assign ad_valid = (state != empty);

    always_ff @(posedge clk) begin
        case (state)
            empty: begin
                cg_ready <= 1'b1;
                if (in_take) begin
                    ad_sheet_addr <= sheet_addr;
                    ad_fb_addr    <= fb_addr;
                    state         <= full;
                end
            end
            full: begin
                if (in_take && !out_take) begin  // park the new item
                    buf_sheet_addr <= sheet_addr;
                    buf_fb_addr    <= fb_addr;
                    cg_ready       <= 1'b0;
                    state          <= buf_full;
                end else if (in_take) begin
                    ad_sheet_addr <= sheet_addr;
                    ad_fb_addr    <= fb_addr;
                end else if (out_take) begin
                    state <= empty;
                end
            end
            buf_full: begin
                if (out_take) begin
                    ad_sheet_addr <= buf_sheet_addr;
                    ad_fb_addr    <= buf_fb_addr;
                    cg_ready      <= 1'b1;
                    state         <= full;
                end
            end
            default: state <= empty;
        endcase

        if (rst) begin
            state    <= empty;
            cg_ready <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/blit_pixel_fetch.sv
`default_nettype none

module blit_pixel_fetch import blit_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    ad_valid,
    output logic                    ad_ready,
    input  logic [sheet_addr_w-1:0] ad_sheet_addr,
    input  logic [fb_addr_w-1:0]    ad_fb_addr,

    output logic                    sheet_rd_en,
    output logic [sheet_addr_w-1:0] sheet_rd_addr,
    input  logic [index_w-1:0]      sheet_rd_data,

    output logic                    px_valid,
    input  logic                    px_ready,
    output logic [index_w-1:0]      px_index,
    output logic [fb_addr_w-1:0]    px_fb_addr
);

    skid_state_t          state;   // held entries, not counting the read in flight
    logic                 pend;    // sheet_rd_data valid this cycle
    logic [fb_addr_w-1:0] pend_fb_addr;
    logic [index_w-1:0]   head_index, buf_index;
    logic [fb_addr_w-1:0] head_addr, buf_addr;

    wire px_take = px_valid && px_ready;

    // held entries plus the read in flight must stay below two
    assign ad_ready      = (state == empty) || (state == full && !pend);
    assign sheet_rd_en   = ad_valid && ad_ready;
    assign sheet_rd_addr = ad_sheet_addr;

    // returning data bypasses the buffer when nothing is queued ahead
    assign px_valid   = (state != empty) || pend;
    assign px_index   = (state == empty) ? sheet_rd_data : head_index;
    assign px_fb_addr = (state == empty) ? pend_fb_addr : head_addr;

    always_ff @(posedge clk) begin
        pend <= sheet_rd_en;
        if (sheet_rd_en) begin
            pend_fb_addr <= ad_fb_addr;  // line up with read latency
        end

        case (state)
            empty: begin
                if (pend && !px_take) begin
                    head_index <= sheet_rd_data;
                    head_addr  <= pend_fb_addr;
                    state      <= full;
                end
            end
            full: begin
                if (px_take && pend) begin
                    head_index <= sheet_rd_data;
                    head_addr  <= pend_fb_addr;
                end else if (px_take) begin
                    state <= empty;
                end else if (pend) begin
                    buf_index <= sheet_rd_data;
                    buf_addr  <= pend_fb_addr;
                    state     <= buf_full;
                end
            end
            buf_full: begin
                if (px_take) begin
                    head_index <= buf_index;
                    head_addr  <= buf_addr;
                    state      <= full;
                end
            end
            default: state <= empty;
        endcase

        if (rst) begin
            state <= empty;
            pend  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/blit_palette_write.sv
`default_nettype none

module blit_palette_write import blit_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 pal_we,
    input  logic [index_w-1:0]   pal_index,
    input  logic [color_w-1:0]   pal_color,

    input  logic                 px_valid,
    output logic                 px_ready,
    input  logic [index_w-1:0]   px_index,
    input  logic [fb_addr_w-1:0] px_fb_addr,

    output logic                 fb_valid,
    input  logic                 fb_ready,
    output logic [fb_addr_w-1:0] fb_addr,
    output logic [color_w-1:0]   fb_data
);

    logic [color_w-1:0] palette [palette_depth];

    wire px_take = px_valid && px_ready;

    assign px_ready = !fb_valid || fb_ready;  // output reg free or draining

    always_ff @(posedge clk) begin
        if (pal_we) begin
            palette[pal_index] <= pal_color;
        end
    end

    always_ff @(posedge clk) begin
        if (px_take) begin
            fb_valid <= (px_index != '0);  // index 0 is transparent
            fb_addr  <= px_fb_addr;
            fb_data  <= palette[px_index];
        end else if (fb_ready) begin
            fb_valid <= 1'b0;
        end

        if (rst) begin
            fb_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/blit_top.sv
`default_nettype none

module blit_top import blit_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  logic [coord_w-1:0]         cmd_src_x,
    input  logic [coord_w-1:0]         cmd_src_y,
    input  logic [sheet_addr_w-1:0]    cmd_sheet_base,
    input  logic [coord_w-1:0]         cmd_sheet_width,
    input  logic [coord_w-1:0]         cmd_dst_x,
    input  logic [coord_w-1:0]         cmd_dst_y,
    input  logic [coord_w-1:0]         cmd_width,
    input  logic [coord_w-1:0]         cmd_height,
    input  logic signed [coord_w-1:0]  cmd_scale_x,
    input  logic signed [coord_w-1:0]  cmd_scale_y,
    input  logic                       cmd_mirror_x,
    input  logic                       cmd_mirror_y,

    output logic                       sheet_rd_en,
    output logic [sheet_addr_w-1:0]    sheet_rd_addr,
    input  logic [index_w-1:0]         sheet_rd_data,

    input  logic                       pal_we,
    input  logic [index_w-1:0]         pal_index,
    input  logic [color_w-1:0]         pal_color,

    output logic                       fb_valid,
    input  logic                       fb_ready,
    output logic [fb_addr_w-1:0]       fb_addr,
    output logic [color_w-1:0]         fb_data,

    output logic                       busy
);

    logic                    cg_valid, cg_ready;
    logic [coord_w-1:0]      cg_sheet_x, cg_sheet_y, cg_screen_x, cg_screen_y;
    logic [sheet_addr_w-1:0] sheet_base;
    logic [coord_w-1:0]      sheet_width;
    logic                    gen_busy;

    logic                    ad_valid, ad_ready;
    logic [sheet_addr_w-1:0] ad_sheet_addr;
    logic [fb_addr_w-1:0]    ad_fb_addr;

    logic                    px_valid, px_ready;
    logic [index_w-1:0]      px_index;
    logic [fb_addr_w-1:0]    px_fb_addr;

    // anything still in flight keeps busy up
    assign busy = gen_busy || ad_valid || px_valid || fb_valid;

    blit_coord_gen u_coord_gen (
        .clk             (clk),
        .rst             (rst),
        .cmd_valid       (cmd_valid),
        .cmd_ready       (cmd_ready),
        .cmd_src_x       (cmd_src_x),
        .cmd_src_y       (cmd_src_y),
        .cmd_sheet_base  (cmd_sheet_base),
        .cmd_sheet_width (cmd_sheet_width),
        .cmd_dst_x       (cmd_dst_x),
        .cmd_dst_y       (cmd_dst_y),
        .cmd_width       (cmd_width),
        .cmd_height      (cmd_height),
        .cmd_scale_x     (cmd_scale_x),
        .cmd_scale_y     (cmd_scale_y),
        .cmd_mirror_x    (cmd_mirror_x),
        .cmd_mirror_y    (cmd_mirror_y),
        .cg_valid        (cg_valid),
        .cg_ready        (cg_ready),
        .cg_sheet_x      (cg_sheet_x),
        .cg_sheet_y      (cg_sheet_y),
        .cg_screen_x     (cg_screen_x),
        .cg_screen_y     (cg_screen_y),
        .sheet_base      (sheet_base),
        .sheet_width     (sheet_width),
        .gen_busy        (gen_busy)
    );

    blit_addr_calc u_addr_calc (
        .clk           (clk),
        .rst           (rst),
        .cg_valid      (cg_valid),
        .cg_ready      (cg_ready),
        .cg_sheet_x    (cg_sheet_x),
        .cg_sheet_y    (cg_sheet_y),
        .cg_screen_x   (cg_screen_x),
        .cg_screen_y   (cg_screen_y),
        .sheet_base    (sheet_base),
        .sheet_width   (sheet_width),
        .ad_valid      (ad_valid),
        .ad_ready      (ad_ready),
        .ad_sheet_addr (ad_sheet_addr),
        .ad_fb_addr    (ad_fb_addr)
    );

    blit_pixel_fetch u_pixel_fetch (
        .clk           (clk),
        .rst           (rst),
        .ad_valid      (ad_valid),
        .ad_ready      (ad_ready),
        .ad_sheet_addr (ad_sheet_addr),
        .ad_fb_addr    (ad_fb_addr),
        .sheet_rd_en   (sheet_rd_en),
        .sheet_rd_addr (sheet_rd_addr),
        .sheet_rd_data (sheet_rd_data),
        .px_valid      (px_valid),
        .px_ready      (px_ready),
        .px_index      (px_index),
        .px_fb_addr    (px_fb_addr)
    );

    blit_palette_write u_palette_write (
        .clk        (clk),
        .rst        (rst),
        .pal_we     (pal_we),
        .pal_index  (pal_index),
        .pal_color  (pal_color),
        .px_valid   (px_valid),
        .px_ready   (px_ready),
        .px_index   (px_index),
        .px_fb_addr (px_fb_addr),
        .fb_valid   (fb_valid),
        .fb_ready   (fb_ready),
        .fb_addr    (fb_addr),
        .fb_data    (fb_data)
    );

endmodule

`default_nettype wire

//--- sim/blit_clk_gen.sv
`default_nettype none

module blit_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // period 20
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/tb_blit.sv
`default_nettype none

module tb_blit import blit_pkg::*; ();

    logic                      clk, rst;
    logic                      cmd_valid, cmd_ready;
    logic [coord_w-1:0]        cmd_src_x, cmd_src_y, cmd_sheet_width;
    logic [coord_w-1:0]        cmd_dst_x, cmd_dst_y, cmd_width, cmd_height;
    logic [sheet_addr_w-1:0]   cmd_sheet_base;
    logic signed [coord_w-1:0] cmd_scale_x, cmd_scale_y;
    logic                      cmd_mirror_x, cmd_mirror_y;
    logic                      sheet_rd_en;
    logic [sheet_addr_w-1:0]   sheet_rd_addr;
    logic [index_w-1:0]        sheet_rd_data;
    logic                      pal_we;
    logic [index_w-1:0]        pal_index;
    logic [color_w-1:0]        pal_color;
    logic                      fb_valid, fb_ready;
    logic [fb_addr_w-1:0]      fb_addr;
    logic [color_w-1:0]        fb_data;
    logic                      busy;

    logic [index_w-1:0]   sheet_mem [4096];
    logic [color_w-1:0]   pal_model [palette_depth];
    logic [fb_addr_w-1:0] exp_addr_q [$];
    logic [color_w-1:0]   exp_data_q [$];
    logic [fb_addr_w-1:0] exp_addr;
    logic [color_w-1:0]   exp_data;
    int                   errors, exp_count, got_count;
    int                   seed = 1328;
    int                   ready_seed = 1328;  // separate stream for fb_ready
    int                   ready_draw, ready_mode;
    bit                   timed_out;

    blit_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    blit_top UUT (.*);

    // sheet contents mix every address bit
    function automatic logic [index_w-1:0] sheet_word(input int a);
        return index_w'(a ^ (a >> 3) ^ (a >> 7) ^ (a >> 11));
    endfunction

    // sheet offset of output pixel i along one axis
    function automatic int axis_offset(input int i, input int scale);
        if (scale > 1) begin
            return i / scale;  // repeat each sheet pixel
        end
        if (scale < -1) begin
            return i * -scale;  // skip ahead
        end
        return i;
    endfunction

    // sheet memory, one cycle read latency
    always @(posedge clk) begin
        if (sheet_rd_en) begin
            assert (sheet_rd_addr < 4096) else begin
                errors++;
                $display("sheet read outside the modelled sheet memory at %h", sheet_rd_addr);
            end
            sheet_rd_data <= sheet_mem[sheet_rd_addr[11:0]];
        end
    end

    // fb_ready pattern: 0 always ready, 1 random, 2 stalled
    always @(posedge clk) begin
        ready_draw = $random(ready_seed);
        case (ready_mode)
            0: fb_ready <= 1'b1;
            1: fb_ready <= ready_draw[0];
            default: fb_ready <= 1'b0;
        endcase
    end

    always @(posedge clk) begin
        if (!rst && fb_valid && fb_ready) begin
            got_count++;
            assert (exp_addr_q.size() != 0) else begin
                errors++;
                $display("framebuffer write to %h that the model does not expect", fb_addr);
            end
            if (exp_addr_q.size() != 0) begin
                exp_addr = exp_addr_q.pop_front();
                exp_data = exp_data_q.pop_front();
                assert (fb_addr == exp_addr) else begin
                    errors++;
                    $display("FAIL fb_addr: got %h, expected %h", fb_addr, exp_addr);
                end
                assert (fb_data == exp_data) else begin
                    errors++;
                    $display("FAIL fb_data: got %h, expected %h", fb_data, exp_data);
                end
            end
        end
    end

    task automatic push_expected(input int sx, sy, base, sw, dx, dy, w, h, scx, scy,
                                 input bit mx, my);
        int                 src_addr;
        int                 scr_x;
        int                 scr_y;
        logic [index_w-1:0] idx;
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                src_addr = base + (sy + axis_offset(y, scy)) * sw + sx + axis_offset(x, scx);
                idx      = sheet_mem[src_addr];
                scr_x    = mx ? dx + w - 1 - x : dx + x;
                scr_y    = my ? dy + h - 1 - y : dy + y;
                if (idx != 0) begin  // index 0 never reaches the framebuffer
                    exp_addr_q.push_back(fb_addr_w'(scr_y * fb_width + scr_x));
                    exp_data_q.push_back(pal_model[idx]);
                    exp_count++;
                end
            end
        end
    endtask

    task automatic load_palette();
        logic [color_w-1:0] color;
        if (timed_out) return;
        for (int i = 0; i < palette_depth; i++) begin
            color = $random(seed);
            pal_model[i] = color;
            @(posedge clk);
            pal_we    <= 1'b1;
            pal_index <= index_w'(i);
            pal_color <= color;
        end
        @(posedge clk);
        pal_we <= 1'b0;
    endtask

    task automatic issue_command(input int sx, sy, base, sw, dx, dy, w, h, scx, scy,
                                 input bit mx, my);
        int waited;
        waited = 0;
        if (timed_out) return;
        push_expected(sx, sy, base, sw, dx, dy, w, h, scx, scy, mx, my);
        @(posedge clk);
        cmd_valid       <= 1'b1;
        cmd_src_x       <= coord_w'(sx);
        cmd_src_y       <= coord_w'(sy);
        cmd_sheet_base  <= sheet_addr_w'(base);
        cmd_sheet_width <= coord_w'(sw);
        cmd_dst_x       <= coord_w'(dx);
        cmd_dst_y       <= coord_w'(dy);
        cmd_width       <= coord_w'(w);
        cmd_height      <= coord_w'(h);
        cmd_scale_x     <= coord_w'(scx);
        cmd_scale_y     <= coord_w'(scy);
        cmd_mirror_x    <= mx;
        cmd_mirror_y    <= my;
        do begin
            @(posedge clk);
            waited++;
        end while (!cmd_ready && waited < 4000);
        cmd_valid <= 1'b0;
        if (!cmd_ready) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: command not accepted after %0d cycles", waited);
            return;
        end
        @(posedge clk);
        assert (!cmd_ready && busy) else begin
            errors++;
            $display("cmd_ready did not drop or busy did not rise after a command");
        end
    endtask

    task automatic random_command(input bit scaled, input bit mirrored);
        int sx, sy, base, sw, dx, dy, w, h;
        int scx, scy;
        bit mx, my;
        sx   = {$random(seed)} % 16;
        sy   = {$random(seed)} % 16;
        base = {$random(seed)} % 1024;
        sw   = 48 + {$random(seed)} % 17;
        dx   = {$random(seed)} % 300;
        dy   = {$random(seed)} % 200;
        w    = 1 + {$random(seed)} % 8;
        h    = 1 + {$random(seed)} % 6;
        scx  = scaled ? $random(seed) % 5 : 1;  // -4 .. 4
        scy  = scaled ? $random(seed) % 5 : 1;
        mx   = mirrored && ($random(seed) & 1);
        my   = mirrored && ($random(seed) & 1);
        issue_command(sx, sy, base, sw, dx, dy, w, h, scx, scy, mx, my);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        if (timed_out) return;
        do begin
            @(posedge clk);
            waited++;
            assert (cmd_ready || busy) else begin
                errors++;
                $display("cmd_ready low while the blitter is not busy");
            end
        end while (busy && waited < 4000);
        if (busy) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: blitter still busy after %0d cycles", waited);
        end else begin
            assert (exp_addr_q.size() == 0) else begin
                errors++;
                $display("command ended with %0d expected writes missing", exp_addr_q.size());
            end
        end
    endtask

    initial begin
        int waited;
        cmd_valid       = 1'b0;
        cmd_src_x       = '0;
        cmd_src_y       = '0;
        cmd_sheet_base  = '0;
        cmd_sheet_width = '0;
        cmd_dst_x       = '0;
        cmd_dst_y       = '0;
        cmd_width       = '0;
        cmd_height      = '0;
        cmd_scale_x     = '0;
        cmd_scale_y     = '0;
        cmd_mirror_x    = 1'b0;
        cmd_mirror_y    = 1'b0;
        sheet_rd_data   = '0;
        pal_we          = 1'b0;
        pal_index       = '0;
        pal_color       = '0;
        fb_ready        = 1'b1;
        ready_mode      = 0;
        errors          = 0;
        exp_count       = 0;
        got_count       = 0;
        timed_out       = 1'b0;
        for (int a = 0; a < 4096; a++) begin
            sheet_mem[a] = sheet_word(a);
        end

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (rst && waited < 100);
        if (rst) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: reset never released");
        end

        // idle after reset
        repeat (8) begin
            @(posedge clk);
            assert (!fb_valid && !busy) else begin
                errors++;
                $display("fb_valid or busy high with no command given");
            end
        end
        assert (cmd_ready) else begin
            errors++;
            $display("cmd_ready low while idle after reset");
        end

        load_palette();
        issue_command(3, 2, 100, 64, 10, 20, 8, 4, 1, 0, 1'b0, 1'b0);  // plain 1:1
        wait_idle();

        repeat (6) begin
            random_command(1'b1, 1'b0);
            wait_idle();
        end

        load_palette();
        repeat (6) begin
            random_command(1'b1, 1'b1);
            wait_idle();
        end

        // stall the framebuffer on a large command
        ready_mode <= 2;
        issue_command(5, 1, 300, 56, 40, 60, 8, 6, -2, 3, 1'b1, 1'b0);
        repeat (40) begin
            @(posedge clk);
            assert (!cmd_ready && busy) else begin
                errors++;
                $display("command input reopened while the framebuffer was stalled");
            end
        end
        ready_mode <= 1;
        wait_idle();
        repeat (6) begin
            random_command(1'b1, 1'b1);
            wait_idle();
        end

        // back to back, drained once at the end
        repeat (8) begin
            random_command(1'b1, 1'b1);
        end
        wait_idle();

        assert (got_count == exp_count) else begin
            errors++;
            $display("FAIL write count: got %h, expected %h", got_count, exp_count);
        end
        $display("errors: %0d, writes seen: %0d, writes expected: %0d",
                 errors, got_count, exp_count);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hdl/blit_pkg.sv
hdl/blit_coord_gen.sv
hdl/blit_addr_calc.sv
hdl/blit_pixel_fetch.sv
hdl/blit_palette_write.sv
hdl/blit_top.sv
sim/blit_clk_gen.sv
sim/tb_blit.sv

//--- Bender.yml
package:
  name: blit

sources:
  - files:
      - hdl/blit_pkg.sv
      - hdl/blit_coord_gen.sv
      - hdl/blit_addr_calc.sv
      - hdl/blit_pixel_fetch.sv
      - hdl/blit_palette_write.sv
      - hdl/blit_top.sv
  - target: simulation
    files:
      - sim/blit_clk_gen.sv
      - sim/tb_blit.sv
